// ==== source/fdiv_pkg.sv ====
/*
 * shared definitions for the binary64 divider
 *   widths and typedefs for operands, significands and MAC products
 *   fclass bit indices
 *   request, result, flag and MAC bus structs
 */
package fdiv_pkg;

    typedef logic [63:0]        fp64_t;
    typedef logic [9:0]         fclass_t;
    // 1.0 at bit 54, two zero guard bits below the fraction
    typedef logic [55:0]        sig_t;
    typedef logic [109:0]       prod_t;
    typedef logic signed [13:0] exp_t;
    typedef logic [52:0]        mant_t;
    typedef logic [2:0]         rm_t;

    // fclass one-hot positions
    localparam int CLS_NEG_INF  = 0;
    localparam int CLS_NEG_NORM = 1;
    localparam int CLS_NEG_SUB  = 2;
    localparam int CLS_NEG_ZERO = 3;
    localparam int CLS_POS_ZERO = 4;
    localparam int CLS_POS_SUB  = 5;
    localparam int CLS_POS_NORM = 6;
    localparam int CLS_POS_INF  = 7;
    localparam int CLS_SNAN     = 8;
    localparam int CLS_QNAN     = 9;

    localparam sig_t SIG_ONE     = 56'h40_0000_0000_0000;
    localparam exp_t EXP_BIAS    = 14'sd1023;
    localparam exp_t MAX_SHIFT   = 14'sd54;
    localparam int   LUT_INDEX_W = 7;

    typedef struct packed {
        logic snan;
        logic qnan;
        logic dbz;
        logic infs;
        logic zero;
    } fdiv_flags_t;

    typedef struct packed {
        fp64_t   a;
        fp64_t   b;
        fclass_t class_a;
        fclass_t class_b;
        rm_t     rm;
    } fdiv_req_t;

    // pre-rounding bundle
    typedef struct packed {
        logic        sign;
        exp_t        expo;
        mant_t       mant;
        logic [2:0]  grs;
        logic [1:0]  rema;
        rm_t         rm;
        fdiv_flags_t flags;
    } fdiv_res_t;

    // d = a * 2^54 +/- b * c
    typedef struct packed {
        logic valid;
        logic sub;
        sig_t a;
        sig_t b;
        sig_t c;
    } mac_req_t;

    typedef struct packed {
        logic  ready;
        prod_t d;
    } mac_res_t;

endpackage

// ==== source/fdiv_recip_lut.sv ====
/*
 * reciprocal seed table for significands in [1, 2)
 * 128 entries, 8 fraction bits, entry 0 means 1.0
 */
module fdiv_recip_lut (
    input  logic [fdiv_pkg::LUT_INDEX_W-1:0] index_i,
    output logic [7:0]                       seed_o
);

    // seed roughly 1 / (1 + (index + 0.5) / 128)
    localparam logic [7:0] RECIP_TABLE [128] = '{
        8'h00, 8'hfe, 8'hfc, 8'hfa, 8'hf8, 8'hf6, 8'hf4, 8'hf2,
        8'hf0, 8'hef, 8'hed, 8'heb, 8'hea, 8'he8, 8'he6, 8'he5,
        8'he3, 8'he1, 8'he0, 8'hde, 8'hdd, 8'hdb, 8'hda, 8'hd9,
        8'hd7, 8'hd6, 8'hd4, 8'hd3, 8'hd2, 8'hd0, 8'hcf, 8'hce,
        8'hcc, 8'hcb, 8'hca, 8'hc9, 8'hc7, 8'hc6, 8'hc5, 8'hc4,
        8'hc3, 8'hc1, 8'hc0, 8'hbf, 8'hbe, 8'hbd, 8'hbc, 8'hbb,
        8'hba, 8'hb9, 8'hb8, 8'hb7, 8'hb6, 8'hb5, 8'hb4, 8'hb3,
        8'hb2, 8'hb1, 8'hb0, 8'haf, 8'hae, 8'had, 8'hac, 8'hab,
        8'haa, 8'ha9, 8'ha8, 8'ha8, 8'ha7, 8'ha6, 8'ha5, 8'ha4,
        8'ha3, 8'ha3, 8'ha2, 8'ha1, 8'ha0, 8'h9f, 8'h9f, 8'h9e,
        8'h9d, 8'h9c, 8'h9c, 8'h9b, 8'h9a, 8'h99, 8'h99, 8'h98,
        8'h97, 8'h97, 8'h96, 8'h95, 8'h94, 8'h94, 8'h93, 8'h92,
        8'h92, 8'h91, 8'h90, 8'h90, 8'h8f, 8'h8f, 8'h8e, 8'h8d,
        8'h8d, 8'h8c, 8'h8c, 8'h8b, 8'h8a, 8'h8a, 8'h89, 8'h89,
        8'h88, 8'h87, 8'h87, 8'h86, 8'h86, 8'h85, 8'h85, 8'h84,
        8'h84, 8'h83, 8'h83, 8'h82, 8'h82, 8'h81, 8'h81, 8'h80
    };

    assign seed_o = RECIP_TABLE[index_i];

endmodule

// ==== source/fdiv_special.sv ====
/*
 * exception decode for division
 * one flag at most, in order snan, qnan, infs, dbz, zero
 */
module fdiv_special (
    input  fdiv_pkg::fclass_t     class_a_i,
    input  fdiv_pkg::fclass_t     class_b_i,
    output fdiv_pkg::fdiv_flags_t flags_o
);

    logic a_zero, b_zero;
    logic a_inf, b_inf;
    logic a_nz_fin, b_fin;
    logic any_snan, any_qnan;

    always_comb begin
        a_zero   = class_a_i[fdiv_pkg::CLS_NEG_ZERO] | class_a_i[fdiv_pkg::CLS_POS_ZERO];
        b_zero   = class_b_i[fdiv_pkg::CLS_NEG_ZERO] | class_b_i[fdiv_pkg::CLS_POS_ZERO];
        a_inf    = class_a_i[fdiv_pkg::CLS_NEG_INF] | class_a_i[fdiv_pkg::CLS_POS_INF];
        b_inf    = class_b_i[fdiv_pkg::CLS_NEG_INF] | class_b_i[fdiv_pkg::CLS_POS_INF];
        a_nz_fin = class_a_i[fdiv_pkg::CLS_NEG_NORM] | class_a_i[fdiv_pkg::CLS_NEG_SUB] |
                   class_a_i[fdiv_pkg::CLS_POS_SUB] | class_a_i[fdiv_pkg::CLS_POS_NORM];
        b_fin    = b_zero |
                   class_b_i[fdiv_pkg::CLS_NEG_NORM] | class_b_i[fdiv_pkg::CLS_NEG_SUB] |
                   class_b_i[fdiv_pkg::CLS_POS_SUB] | class_b_i[fdiv_pkg::CLS_POS_NORM];
        any_snan = class_a_i[fdiv_pkg::CLS_SNAN] | class_b_i[fdiv_pkg::CLS_SNAN];
        any_qnan = class_a_i[fdiv_pkg::CLS_QNAN] | class_b_i[fdiv_pkg::CLS_QNAN];

        flags_o = '0;
        // invalid: signalling input, 0/0, inf/inf
        if (any_snan | (a_zero & b_zero) | (a_inf & b_inf)) begin
            flags_o.snan = 1'b1;
        end else if (any_qnan) begin
            flags_o.qnan = 1'b1;
        end else if (a_inf & b_fin) begin
            flags_o.infs = 1'b1;
        end else if (a_nz_fin & b_zero) begin
            flags_o.dbz = 1'b1;
        end else if (a_zero | b_inf) begin
            flags_o.zero = 1'b1;
        end
    end

endmodule

// ==== source/fdiv_mac.sv ====
/*
 * pipelined 56-bit multiply-accumulate
 *   d = a * 2^54 +/- b * c, signed, 110-bit result
 *   LATENCY register stages with matching valid chain
 */
module fdiv_mac #(
    parameter int unsigned LATENCY = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    input  fdiv_pkg::mac_req_t mac_i,
    output fdiv_pkg::mac_res_t mac_o
);

    logic signed [109:0] prod;
    fdiv_pkg::prod_t     acc;
    logic [LATENCY-1:0]  valid_q;
    fdiv_pkg::prod_t     acc_q [LATENCY];

    // operands are two's complement, bit 55 is the sign
    always_comb begin
        prod = $signed(mac_i.b) * $signed(mac_i.c);
        if (mac_i.sub) begin
            acc = {mac_i.a, 54'b0} - prod;
        end else begin
            acc = {mac_i.a, 54'b0} + prod;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= mac_i.valid;
            for (int i = 1; i < LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        acc_q[0] <= acc;
        for (int i = 1; i < LATENCY; i++) begin
            acc_q[i] <= acc_q[i-1];
        end
    end

    assign mac_o.ready = valid_q[LATENCY-1];
    assign mac_o.d     = acc_q[LATENCY-1];

endmodule

// ==== source/fdiv_iter_ctrl.sv ====
/*
 * divider sequencer
 *   operand capture and reciprocal seed
 *   eleven MAC steps: reciprocal refinement, quotient, remainder correction
 *   iteration registers and quotient hand-off to normalization
 */
module fdiv_iter_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  fdiv_pkg::fdiv_req_t   req_i,
    output fdiv_pkg::mac_req_t    mac_o,
    input  fdiv_pkg::mac_res_t    mac_i,
    output fdiv_pkg::fdiv_flags_t flags_o,
    output logic                  q_valid_o,
    output fdiv_pkg::sig_t        q_o,
    output fdiv_pkg::prod_t       r_o,
    output logic                  sign_o,
    output fdiv_pkg::exp_t        exp_diff_o,
    output fdiv_pkg::rm_t         rm_o
);

    typedef enum logic [1:0] {
        idle,
        iterate,
        done
    } state_e;

    typedef enum logic [3:0] {
        calc_e0,
        calc_y0,
        calc_e1,
        calc_y1,
        calc_e2,
        calc_y2,
        calc_q0,
        calc_r0,
        refine_q0,
        calc_r1,
        final_check
    } step_e;

    state_e state_q;
    step_e  step_q;
    logic   issued_q;
    logic   capture;

    logic [fdiv_pkg::LUT_INDEX_W-1:0] lut_index;
    logic [7:0]                       seed;

    fdiv_pkg::sig_t    qa_q, qb_q, y_q;
    fdiv_pkg::sig_t    e0_q, e1_q, e2_q;
    fdiv_pkg::sig_t    y0_q, y1_q, y2_q;
    fdiv_pkg::sig_t    q0_q, q1_q, r0_q;
    fdiv_pkg::prod_t   r_q;
    fdiv_pkg::fclass_t class_a_q, class_b_q;
    fdiv_pkg::exp_t    exp_diff_q;
    fdiv_pkg::rm_t     rm_q;
    logic              sign_q;

    fdiv_pkg::sig_t  mac_top;
    fdiv_pkg::prod_t rem_less_b, rem_less_2b;
    fdiv_pkg::sig_t  q1_next;

    assign capture   = (state_q == idle) && start_i;
    assign lut_index = req_i.b[51:45];
    assign mac_top   = mac_i.d[109:54];

    // q0 after refinement is at most two below the floor quotient
    assign rem_less_b  = mac_i.d - {54'b0, qb_q};
    assign rem_less_2b = mac_i.d - {53'b0, qb_q, 1'b0};
    assign q1_next     = q0_q + {55'b0, ~rem_less_b[109]} + {55'b0, ~rem_less_2b[109]};

    fdiv_recip_lut u_recip_lut (
        .index_i(lut_index),
        .seed_o (seed)
    );

    fdiv_special u_special (
        .class_a_i(class_a_q),
        .class_b_i(class_b_q),
        .flags_o  (flags_o)
    );

    // operand select per step
    always_comb begin
        mac_o.valid = (state_q == iterate) && !issued_q;
        mac_o.sub   = 1'b0;
        mac_o.a     = '0;
        mac_o.b     = '0;
        mac_o.c     = '0;
        case (step_q)
            calc_e0: begin
                mac_o.sub = 1'b1;
                mac_o.a   = fdiv_pkg::SIG_ONE;
                mac_o.b   = qb_q;
                mac_o.c   = y_q;
            end
            calc_y0: begin
                mac_o.a = y_q;
                mac_o.b = y_q;
                mac_o.c = e0_q;
            end
            calc_e1: begin
                mac_o.b = e0_q;
                mac_o.c = e0_q;
            end
            calc_y1: begin
                mac_o.a = y0_q;
                mac_o.b = y0_q;
                mac_o.c = e1_q;
            end
            calc_e2: begin
                mac_o.b = e1_q;
                mac_o.c = e1_q;
            end
            calc_y2: begin
                mac_o.a = y1_q;
                mac_o.b = y1_q;
                mac_o.c = e2_q;
            end
            calc_q0: begin
                mac_o.b = qa_q;
                mac_o.c = y2_q;
            end
            refine_q0: begin
                mac_o.a = q0_q;
                mac_o.b = r0_q;
                mac_o.c = y2_q;
            end
            calc_r0, calc_r1: begin
                mac_o.sub = 1'b1;
                mac_o.a   = qa_q;
                mac_o.b   = qb_q;
                mac_o.c   = q0_q;
            end
            final_check: begin
                mac_o.sub = 1'b1;
                mac_o.a   = qa_q;
                mac_o.b   = qb_q;
                mac_o.c   = q1_q;
            end
            default: begin
                mac_o.valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= idle;
            step_q   <= calc_e0;
            issued_q <= 1'b0;
        end else begin
            case (state_q)
                idle: begin
                    if (start_i) begin
                        state_q  <= iterate;
                        step_q   <= calc_e0;
                        issued_q <= 1'b0;
                    end
                end
                iterate: begin
                    if (mac_o.valid) begin
                        issued_q <= 1'b1;
                    end
                    if (mac_i.ready) begin
                        issued_q <= 1'b0;
                        if (step_q == final_check) begin
                            state_q <= done;
                        end else begin
                            step_q <= step_e'(step_q + 4'd1);
                        end
                    end
                end
                done: begin
                    state_q <= idle;
                end
                default: begin
                    state_q <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            qa_q       <= {2'b01, req_i.a[51:0], 2'b00};
            qb_q       <= {2'b01, req_i.b[51:0], 2'b00};
            y_q        <= {1'b0, (lut_index == '0), seed, 46'b0};
            sign_q     <= req_i.a[63] ^ req_i.b[63];
            exp_diff_q <= {3'b0, req_i.a[62:52]} - {3'b0, req_i.b[62:52]};
            class_a_q  <= req_i.class_a;
            class_b_q  <= req_i.class_b;
            rm_q       <= req_i.rm;
        end
        if ((state_q == iterate) && mac_i.ready) begin
            case (step_q)
                calc_e0:     e0_q <= mac_top;
                calc_y0:     y0_q <= mac_top;
                calc_e1:     e1_q <= mac_top;
                calc_y1:     y1_q <= mac_top;
                calc_e2:     e2_q <= mac_top;
                calc_y2:     y2_q <= mac_top;
                calc_q0:     q0_q <= mac_top;
                calc_r0:     r0_q <= mac_top;
                refine_q0:   q0_q <= mac_top;
                calc_r1:     q1_q <= q1_next;
                final_check: r_q  <= mac_i.d;
                default:     r_q  <= mac_i.d;
            endcase
        end
    end

    assign q_valid_o  = (state_q == done);
    assign q_o        = q1_q;
    assign r_o        = r_q;
    assign sign_o     = sign_q;
    assign exp_diff_o = exp_diff_q;
    assign rm_o       = rm_q;

endmodule

// ==== source/fdiv_normalize.sv ====
/*
 * quotient normalization
 *   leading-one shift, biased exponent, underflow right shift
 *   mantissa and guard/round/sticky, remainder sign, result register
 */
module fdiv_normalize (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  q_valid_i,
    input  fdiv_pkg::sig_t        q_i,
    input  fdiv_pkg::prod_t       r_i,
    input  logic                  sign_i,
    input  fdiv_pkg::exp_t        exp_diff_i,
    input  fdiv_pkg::rm_t         rm_i,
    input  fdiv_pkg::fdiv_flags_t flags_i,
    output fdiv_pkg::fdiv_res_t   res_o,
    output logic                  ready_o
);

    logic                lshift;
    fdiv_pkg::sig_t      q_norm;
    fdiv_pkg::exp_t      expo_pre;
    fdiv_pkg::exp_t      expo;
    fdiv_pkg::exp_t      rshift;
    logic [113:0]        mant_ext;
    logic [1:0]          rema;
    fdiv_pkg::fdiv_res_t res_q;
    logic                ready_q;

    always_comb begin
        lshift   = ~q_i[54];
        q_norm   = lshift ? (q_i << 1) : q_i;
        expo_pre = exp_diff_i + fdiv_pkg::EXP_BIAS - {13'b0, lshift};

        // underflow: denormalize, shift capped
        expo   = expo_pre;
        rshift = '0;
        if (expo_pre <= 0) begin
            rshift = 14'sd1 - expo_pre;
            if (rshift > fdiv_pkg::MAX_SHIFT) begin
                rshift = fdiv_pkg::MAX_SHIFT;
            end
            expo = '0;
        end
        // wide enough that nothing is lost by the shift
        mant_ext = {q_norm[54:0], 59'b0} >> rshift[5:0];

        if (r_i == '0) begin
            rema = 2'd0;
        end else if (!r_i[109]) begin
            rema = 2'd1;
        end else begin
            rema = 2'd2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= q_valid_i;
            if (q_valid_i) begin
                res_q.sign  <= sign_i;
                res_q.expo  <= expo;
                res_q.mant  <= mant_ext[113:61];
                res_q.grs   <= {mant_ext[60], mant_ext[59], |mant_ext[58:0]};
                res_q.rema  <= rema;
                res_q.rm    <= rm_i;
                res_q.flags <= flags_i;
            end
        end
    end

    assign res_o   = res_q;
    assign ready_o = ready_q;

endmodule

// ==== source/fdiv_top.sv ====
/*
 * binary64 divider top level
 * sequencer, shared MAC and normalization stage
 */
module fdiv_top #(
    parameter int unsigned MAC_LATENCY = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  fdiv_pkg::fdiv_req_t req_i,
    output fdiv_pkg::fdiv_res_t res_o,
    output logic                ready_o
);

    fdiv_pkg::mac_req_t    mac_req;
    fdiv_pkg::mac_res_t    mac_res;
    fdiv_pkg::fdiv_flags_t flags;
    logic                  q_valid;
    fdiv_pkg::sig_t        q;
    fdiv_pkg::prod_t       r;
    logic                  sign;
    fdiv_pkg::exp_t        exp_diff;
    fdiv_pkg::rm_t         rm;

    fdiv_iter_ctrl u_iter_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .req_i     (req_i),
        .mac_o     (mac_req),
        .mac_i     (mac_res),
        .flags_o   (flags),
        .q_valid_o (q_valid),
        .q_o       (q),
        .r_o       (r),
        .sign_o    (sign),
        .exp_diff_o(exp_diff),
        .rm_o      (rm)
    );

    fdiv_mac #(
        .LATENCY(MAC_LATENCY)
    ) u_mac (
        .clk  (clk),
        .rst_n(rst_n),
        .mac_i(mac_req),
        .mac_o(mac_res)
    );

    fdiv_normalize u_normalize (
        .clk       (clk),
        .rst_n     (rst_n),
        .q_valid_i (q_valid),
        .q_i       (q),
        .r_i       (r),
        .sign_i    (sign),
        .exp_diff_i(exp_diff),
        .rm_i      (rm),
        .flags_i   (flags),
        .res_o     (res_o),
        .ready_o   (ready_o)
    );

endmodule

// ==== testbench/tb_fdiv_model.svh ====
/*
 * reference model for the divider testbench
 *   Fibonacci LFSR and random operand generation
 *   fclass vector of an encoding, expected exception flags
 *   expected pre-rounding result
 */
`ifndef TB_FDIV_MODEL_SVH
`define TB_FDIV_MODEL_SVH

logic [31:0] lfsr = 32'h1a94127d;

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);
        v = {v[62:0], lfsr[0]};
    end
    return v;
endfunction

// normal operand, exponent kept near the bias
function automatic fdiv_pkg::fp64_t random_normal();
    logic [63:0] v;
    v = take_bits(64);
    v[62:52] = 11'd960 + {3'b000, v[59:52]};
    return v;
endfunction

function automatic fdiv_pkg::fclass_t classify(input fdiv_pkg::fp64_t x);
    fdiv_pkg::fclass_t c;
    c = '0;
    if (x[62:52] == 11'h7ff) begin
        if (x[51:0] == '0) begin
            c[x[63] ? fdiv_pkg::CLS_NEG_INF : fdiv_pkg::CLS_POS_INF] = 1'b1;
        end else begin
            c[x[51] ? fdiv_pkg::CLS_QNAN : fdiv_pkg::CLS_SNAN] = 1'b1;
        end
    end else if (x[62:52] == 11'h000) begin
        if (x[51:0] == '0) begin
            c[x[63] ? fdiv_pkg::CLS_NEG_ZERO : fdiv_pkg::CLS_POS_ZERO] = 1'b1;
        end else begin
            c[x[63] ? fdiv_pkg::CLS_NEG_SUB : fdiv_pkg::CLS_POS_SUB] = 1'b1;
        end
    end else begin
        c[x[63] ? fdiv_pkg::CLS_NEG_NORM : fdiv_pkg::CLS_POS_NORM] = 1'b1;
    end
    return c;
endfunction

function automatic fdiv_pkg::fdiv_flags_t expected_flags(input fdiv_pkg::fp64_t a,
                                                          input fdiv_pkg::fp64_t b);
    logic a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
    fdiv_pkg::fdiv_flags_t f;
    a_nan  = (&a[62:52]) && (a[51:0] != '0);
    b_nan  = (&b[62:52]) && (b[51:0] != '0);
    a_inf  = (&a[62:52]) && (a[51:0] == '0);
    b_inf  = (&b[62:52]) && (b[51:0] == '0);
    a_zero = (a[62:0] == '0);
    b_zero = (b[62:0] == '0);
    f = '0;
    if ((a_nan && !a[51]) || (b_nan && !b[51]) || (a_zero && b_zero) || (a_inf && b_inf)) begin
        f.snan = 1'b1;
    end else if (a_nan || b_nan) begin
        f.qnan = 1'b1;
    end else if (a_inf) begin
        f.infs = 1'b1;
    end else if (b_zero) begin
        f.dbz = 1'b1;
    end else if (a_zero || b_inf) begin
        f.zero = 1'b1;
    end
    return f;
endfunction

function automatic fdiv_pkg::fdiv_res_t expected_result(input fdiv_pkg::fp64_t a,
                                                         input fdiv_pkg::fp64_t b,
                                                         input fdiv_pkg::rm_t rm);
    fdiv_pkg::fdiv_res_t r;
    logic [111:0] num, quo, rem;
    logic [55:0]  ma, mb;
    logic [54:0]  qn;
    logic [127:0] ext;
    int ea, eb, e, sh;
    ma  = {2'b01, a[51:0], 2'b00};
    mb  = {2'b01, b[51:0], 2'b00};
    num = {ma, 54'b0};
    quo = num / {56'b0, mb};
    rem = num - quo * {56'b0, mb};
    ea  = a[62:52];
    eb  = b[62:52];
    e   = ea - eb + 1023;
    if (quo[54]) begin
        qn = quo[54:0];
    end else begin
        qn = {quo[53:0], 1'b0};
        e  = e - 1;
    end
    sh = 0;
    if (e <= 0) begin
        sh = (1 - e > 54) ? 54 : 1 - e;
        e  = 0;
    end
    ext     = {qn, 73'b0} >> sh;
    r.sign  = a[63] ^ b[63];
    r.expo  = e[13:0];
    r.mant  = ext[127:75];
    r.grs   = {ext[74], ext[73], |ext[72:0]};
    r.rema  = (rem == '0) ? 2'd0 : 2'd1;
    r.rm    = rm;
    r.flags = expected_flags(a, b);
    return r;
endfunction

`endif

// ==== testbench/tb_fdiv.sv ====
/*
 * testbench for the binary64 divider
 *   clock, reset and start strobe stimulus
 *   random, exact, exception and underflow divisions
 *   ready_o pulse monitor and closing report
 */
module tb_fdiv;

    `include "tb_fdiv_model.svh"

    localparam int DRIVE_DELAY    = 2;
    localparam int TIMEOUT_CYCLES = 200;

    localparam logic [63:0] FP_POS_ZERO = 64'h0000_0000_0000_0000;
    localparam logic [63:0] FP_NEG_ZERO = 64'h8000_0000_0000_0000;
    localparam logic [63:0] FP_POS_INF  = 64'h7ff0_0000_0000_0000;
    localparam logic [63:0] FP_NEG_INF  = 64'hfff0_0000_0000_0000;
    localparam logic [63:0] FP_QNAN     = 64'h7ff8_0000_0000_0000;
    localparam logic [63:0] FP_SNAN     = 64'h7ff0_0000_0000_0001;
    localparam logic [63:0] FP_ONE      = 64'h3ff0_0000_0000_0000;
    localparam logic [63:0] FP_THREE    = 64'h4008_0000_0000_0000;

    logic                clk;
    logic                rst_n;
    logic                start_i;
    fdiv_pkg::fdiv_req_t req_i;
    fdiv_pkg::fdiv_res_t res_o;
    logic                ready_o;

    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;
    int accepted = 0;
    int pulses   = 0;
    logic ready_last = 1'b0;

    fdiv_top #(
        .MAC_LATENCY(3)
    ) u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start_i(start_i),
        .req_i  (req_i),
        .res_o  (res_o),
        .ready_o(ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // every ready_o pulse is one cycle wide and follows an accepted start
    always @(negedge clk) begin
        if (rst_n) begin
            if (ready_o) begin
                pulses++;
                assert (!ready_last) else begin
                    errors++;
                    $display("ready_o at time %0t stayed high for more than one cycle", $time);
                end
                assert (pulses <= accepted) else begin
                    errors++;
                    $display("ready_o at time %0t pulsed with no accepted start", $time);
                end
            end
            ready_last = ready_o;
        end
    end

    // wide enough for the whole result bundle
    task automatic check_field(input string name, input logic [127:0] expv,
                               input logic [127:0] actv);
        checks++;
        assert (actv === expv) else begin
            errors++;
            $display("Error at time %0t: %s expected %h, got %h", $time, name, expv, actv);
        end
    endtask

    task automatic pulse_start(input fdiv_pkg::fp64_t a, input fdiv_pkg::fp64_t b,
                               input fdiv_pkg::rm_t rm, input bit counts);
        @(posedge clk);
        #DRIVE_DELAY;
        req_i.a       = a;
        req_i.b       = b;
        req_i.class_a = classify(a);
        req_i.class_b = classify(b);
        req_i.rm      = rm;
        start_i       = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start_i = 1'b0;
        if (counts) begin
            accepted++;
        end
    endtask

    task automatic wait_ready(output bit got);
        int cycles;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (ready_o) begin
                got = 1'b1;
            end
        end
        if (!got) begin
            errors++;
            timeouts++;
            $display("no result arrived within %0d cycles at time %0t", TIMEOUT_CYCLES, $time);
        end
    endtask

    // datapath fields are only meaningful without an exception
    task automatic check_result(input fdiv_pkg::fp64_t a, input fdiv_pkg::fp64_t b,
                                input fdiv_pkg::rm_t rm, input bit full);
        fdiv_pkg::fdiv_res_t exp_res;
        exp_res = expected_result(a, b, rm);
        check_field("res_o.flags", exp_res.flags, res_o.flags);
        check_field("res_o.rm", exp_res.rm, res_o.rm);
        if (full) begin
            check_field("res_o.sign", exp_res.sign, res_o.sign);
            check_field("res_o.expo", exp_res.expo, res_o.expo);
            check_field("res_o.mant", exp_res.mant, res_o.mant);
            check_field("res_o.grs", exp_res.grs, res_o.grs);
            check_field("res_o.rema", exp_res.rema, res_o.rema);
        end
    endtask

    task automatic run_division(input fdiv_pkg::fp64_t a, input fdiv_pkg::fp64_t b,
                                input fdiv_pkg::rm_t rm, input bit full);
        bit got;
        pulse_start(a, b, rm, 1'b1);
        wait_ready(got);
        if (got) begin
            check_result(a, b, rm, full);
        end
        @(posedge clk);
        check_field("ready_o pulse count", accepted, pulses);
    endtask

    task automatic check_exact();
        check_field("res_o.rema", 2'd0, res_o.rema);
        check_field("res_o.grs", 3'd0, res_o.grs);
    endtask

    initial begin
        bit          got;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] bits;
        rst_n   = 1'b0;
        start_i = 1'b0;
        req_i   = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // quiet after reset
        repeat (10) @(negedge clk);
        check_field("ready_o pulse count", 0, pulses);
        check_field("res_o", 0, res_o);

        for (int i = 0; i < 40; i++) begin
            a    = random_normal();
            b    = random_normal();
            bits = take_bits(3);
            run_division(a, b, bits[2:0], 1'b1);
        end

        // exact quotients
        run_division(FP_THREE, 64'h3ff8_0000_0000_0000, 3'd0, 1'b1);
        check_exact();
        run_division(FP_ONE, FP_ONE, 3'd1, 1'b1);
        check_exact();
        run_division(64'h401c_0000_0000_0000, 64'h400c_0000_0000_0000, 3'd2, 1'b1);
        check_exact();
        run_division(64'h3ff8_0000_0000_0000, FP_THREE, 3'd3, 1'b1);
        check_exact();
        a = random_normal();
        run_division(a, {1'b1, 11'd1000, a[51:0]}, 3'd4, 1'b1);
        check_exact();

        // exceptions
        run_division(FP_SNAN, FP_ONE, 3'd0, 1'b0);
        run_division(FP_ONE, FP_SNAN, 3'd0, 1'b0);
        run_division(FP_SNAN, FP_QNAN, 3'd0, 1'b0);
        run_division(FP_POS_ZERO, FP_NEG_ZERO, 3'd0, 1'b0);
        run_division(FP_POS_INF, FP_NEG_INF, 3'd0, 1'b0);
        run_division(FP_QNAN, FP_ONE, 3'd1, 1'b0);
        run_division(FP_ONE, FP_QNAN, 3'd1, 1'b0);
        run_division(FP_QNAN, FP_POS_ZERO, 3'd1, 1'b0);
        run_division(FP_THREE, FP_NEG_ZERO, 3'd2, 1'b0);
        run_division(FP_NEG_INF, FP_THREE, 3'd2, 1'b0);
        run_division(FP_POS_INF, FP_POS_ZERO, 3'd2, 1'b0);
        run_division(FP_POS_ZERO, FP_THREE, 3'd3, 1'b0);
        run_division(FP_THREE, FP_POS_INF, 3'd3, 1'b0);
        run_division(FP_NEG_ZERO, FP_NEG_INF, 3'd3, 1'b0);

        // underflow, from a one-bit shift up to the cap
        run_division(64'h0018_0000_0000_0000, 64'h4000_0000_0000_0000, 3'd0, 1'b1);
        bits = take_bits(52);
        run_division({12'h001, bits[51:0]}, {1'b0, 11'd1030, 52'd0}, 3'd0, 1'b1);
        run_division(64'h001c_0000_0000_0001, {1'b0, 11'd1076, 52'd0}, 3'd1, 1'b1);
        run_division(64'h001c_0000_0000_0001, {1'b0, 11'd1077, 52'd0}, 3'd1, 1'b1);
        run_division(64'h001c_0000_0000_0001, {1'b0, 11'd1100, 52'd0}, 3'd2, 1'b1);
        run_division(64'h0010_0000_0000_0000, 64'h7fe0_0000_0000_0000, 3'd2, 1'b1);

        // start while busy is ignored
        a = random_normal();
        b = random_normal();
        pulse_start(a, b, 3'd5, 1'b1);
        repeat (5) @(posedge clk);
        pulse_start(FP_THREE, FP_ONE, 3'd6, 1'b0);
        wait_ready(got);
        if (got) begin
            check_result(a, b, 3'd5, 1'b1);
        end
        repeat (TIMEOUT_CYCLES) @(negedge clk);
        check_field("ready_o pulse count", accepted, pulses);

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+testbench
source/fdiv_pkg.sv
source/fdiv_recip_lut.sv
source/fdiv_special.sv
source/fdiv_mac.sv
source/fdiv_iter_ctrl.sv
source/fdiv_normalize.sv
source/fdiv_top.sv
testbench/tb_fdiv.sv

// ==== Bender.yml ====
package:
  name: fdiv

sources:
  - source/fdiv_pkg.sv
  - source/fdiv_recip_lut.sv
  - source/fdiv_special.sv
  - source/fdiv_mac.sv
  - source/fdiv_iter_ctrl.sv
  - source/fdiv_normalize.sv
  - source/fdiv_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_fdiv.sv
